// ==== blk_conv.f ====
+incdir+verilog
verilog/mat_data_pkg.sv
verilog/conv_ctrl_pkg.sv
verilog/row_ingest.sv
verilog/row_buffer_ram.sv
verilog/slice_emitter.sv
verilog/blk_conv_top.sv
dv/blk_conv_tb.sv

// ==== Bender.yml ====
package:
  name: blk_conv

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mat_data_pkg.sv
      - verilog/conv_ctrl_pkg.sv
      - verilog/row_ingest.sv
      - verilog/row_buffer_ram.sv
      - verilog/slice_emitter.sv
      - verilog/blk_conv_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/blk_conv_tb.sv

// ==== dv/blk_conv_vectors.txt ====
// Words 0-15: input rows, frame 0 rows 0-7 then frame 1 rows 0-7, element 0 leftmost
// Words 16-31: expected chunks, frame 0 then frame 1, slice row 0 leftmost, column pairs
10001001100210031004100510061007
11001101110211031104110511061107
12001201120212031204120512061207
13001301130213031304130513061307
14001401140214031404140514061407
15001501150215031504150515061507
16001601160216031604160516061607
17001701170217031704170517061707
20002001200220032004200520062007
21002101210221032104210521062107
22002201220222032204220522062207
23002301230223032304230523062307
24002401240224032404240524062407
25002501250225032504250525062507
26002601260226032604260526062607
27002701270227032704270527062707
10001001110011011200120113001301
10021003110211031202120313021303
10041005110411051204120513041305
10061007110611071206120713061307
14001401150015011600160117001701
14021403150215031602160317021703
14041405150415051604160517041705
14061407150615071606160717061707
20002001210021012200220123002301
20022003210221032202220323022303
20042005210421052204220523042305
20062007210621072206220723062307
24002401250025012600260127002701
24022403250225032602260327022703
24042405250425052604260527042705
24062407250625072606260727062707

// ==== dv/blk_conv_tb.sv ====
// Testbench for the row-to-block converter
// Streams frames from the vector file and checks every chunk and flag pair
`timescale 1ns/10ps
`include "blk_conv_defs.svh"

module blk_conv_tb;

    localparam int FRAMES     = 2;
    localparam int CPF        = `BC_SLICES * `BC_CHUNKS_PER_ROW;
    localparam int CHUNK_BASE = FRAMES * `BC_ROW;
    localparam int VEC_WORDS  = CHUNK_BASE + FRAMES * CPF;
    // Frames pushed through the DUT over the whole run, abandoned one included
    localparam int RUN_FRAMES = 7;
    localparam int FRAME_CYC  = `BC_ROW
                              + `BC_SLICES * (`BC_SLICE_ROWS + 1 + `BC_CHUNKS_PER_ROW * 8);
    localparam int TIMEOUT_NS = RUN_FRAMES * FRAME_CYC * 10 * 4;

    logic                        clk;
    logic                        rst_n;
    logic                        in_valid;
    logic                        in_ready;
    mat_data_pkg::row_t          in_row;
    logic                        out_valid;
    logic                        out_ready;
    mat_data_pkg::chunk_t        out_chunk;
    conv_ctrl_pkg::chunk_flags_t out_flags;

    logic [`BC_WIDTH*`BC_COL-1:0] vec_mem [0:VEC_WORDS-1];

    int errors;
    int chunks;
    int tests;
    int err_mark;
    int chunk_mark;
    int rows_seen;
    bit in_closed;
    int unsigned seed_val;

    blk_conv_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_row    (in_row),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_chunk (out_chunk),
        .out_flags (out_flags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Chunk built straight from the stored rows by the ordering rule
    function automatic mat_data_pkg::chunk_t ref_chunk(input int frame, input int idx);
        mat_data_pkg::chunk_t c;
        mat_data_pkg::row_t   row;
        int                   slice;
        int                   col0;
        slice = idx / `BC_CHUNKS_PER_ROW;
        col0  = (idx % `BC_CHUNKS_PER_ROW) * `BC_BLOCK_SIZE;
        for (int r = 0; r < `BC_SLICE_ROWS; r++) begin
            row = mat_data_pkg::row_t'(vec_mem[frame*`BC_ROW + slice*`BC_SLICE_ROWS + r]);
            for (int b = 0; b < `BC_BLOCK_SIZE; b++) begin
                c[r][b] = row[col0 + b];
            end
        end
        return c;
    endfunction

    task automatic apply_reset();
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // in_valid holds with its row until the DUT accepts it
    task automatic send_frame(input int frame, input int gap_pct, input int n_rows);
        for (int r = 0; r < n_rows; r++) begin
            @(negedge clk);
            in_valid = 1'b0;
            while ($urandom_range(99) < gap_pct) @(negedge clk);
            in_valid = 1'b1;
            in_row   = mat_data_pkg::row_t'(vec_mem[frame*`BC_ROW + r]);
            @(posedge clk);
            while (!in_ready) @(posedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic collect_frame(input int frame, input int stall_pct, input string name);
        mat_data_pkg::chunk_t        exp_chunk;
        conv_ctrl_pkg::chunk_flags_t exp_flags;
        int                          got;
        got = 0;
        while (got < CPF) begin
            @(negedge clk);
            out_ready = ($urandom_range(99) >= stall_pct);
            @(posedge clk);
            if (out_valid && out_ready) begin
                exp_chunk            = mat_data_pkg::chunk_t'(vec_mem[CHUNK_BASE + frame*CPF + got]);
                exp_flags.slice_last = ((got + 1) % `BC_CHUNKS_PER_ROW == 0);
                exp_flags.frame_last = (got == CPF - 1);
                if (out_chunk !== exp_chunk) begin
                    errors++;
                    $display("Mismatch %s chunk %0d: expected %h actual %h",
                             name, got, exp_chunk, out_chunk);
                end
                if (out_flags !== exp_flags) begin
                    errors++;
                    $display("Mismatch %s flags %0d: expected %b actual %b",
                             name, got, exp_flags, out_flags);
                end
                got++;
                chunks++;
            end
        end
        @(negedge clk);
        out_ready = 1'b0;
        // Nothing may follow the last chunk of a frame
        if (out_valid !== 1'b0) begin
            errors++;
            $display("%s: out_valid still high after the final chunk of frame %0d", name, frame);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %-12s chunks %0d errors %0d", name, chunks - chunk_mark, errors - err_mark);
        err_mark   = errors;
        chunk_mark = chunks;
    endtask

    // in_ready must stay low from the last accepted row to the final transfer
    always @(posedge clk) begin
        if (!rst_n) begin
            rows_seen = 0;
            in_closed = 1'b0;
        end else begin
            if (in_closed && in_ready) begin
                errors++;
                $display("in_ready rose before the final chunk of the frame transferred");
            end
            if (in_valid && in_ready) begin
                rows_seen++;
                if (rows_seen == `BC_ROW) begin
                    in_closed = 1'b1;
                    rows_seen = 0;
                end
            end
            if (out_valid && out_ready && out_flags.frame_last) begin
                in_closed = 1'b0;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0d ns with chunks still pending", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed_val   = $urandom(32'h2711b8ea);
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_row     = '0;
        out_ready  = 1'b0;
        errors     = 0;
        chunks     = 0;
        tests      = 0;
        err_mark   = 0;
        chunk_mark = 0;
        $readmemh("dv/blk_conv_vectors.txt", vec_mem);
        if ($isunknown(vec_mem[VEC_WORDS-1])) begin
            errors++;
            $display("Vector file is missing or shorter than %0d words", VEC_WORDS);
        end
        for (int i = 0; i < FRAMES * CPF; i++) begin
            if (ref_chunk(i / CPF, i % CPF) !== mat_data_pkg::chunk_t'(vec_mem[CHUNK_BASE + i])) begin
                errors++;
                $display("Vector file chunk %0d disagrees with the chunk ordering rule", i);
            end
        end
        end_test("vector_rule");
        apply_reset();

        fork
            send_frame(0, 0, `BC_ROW);
            collect_frame(0, 0, "straight");
        join
        end_test("straight");

        fork
            send_frame(0, 0, `BC_ROW);
            collect_frame(0, 50, "out_stall");
        join
        end_test("out_stall");

        fork
            send_frame(0, 50, `BC_ROW);
            collect_frame(0, 0, "in_gaps");
        join
        end_test("in_gaps");

        fork
            begin
                send_frame(0, 20, `BC_ROW);
                send_frame(1, 20, `BC_ROW);
            end
            begin
                collect_frame(0, 30, "back_to_back");
                collect_frame(1, 30, "back_to_back");
            end
        join
        end_test("back_to_back");

        // Abandon a frame with a reset while its first chunk is stalled
        send_frame(1, 0, `BC_ROW);
        while (!out_valid) @(negedge clk);
        apply_reset();
        if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
            errors++;
            $display("After reset in_ready is %b and out_valid is %b", in_ready, out_valid);
        end
        fork
            send_frame(1, 10, `BC_ROW);
            collect_frame(1, 20, "reset_mid");
        join
        end_test("reset_mid");

        $display("Summary: %0d tests, %0d chunks checked, %0d errors", tests, chunks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verilog/blk_conv_top.sv ====
// Row-to-block converter
// Takes a matrix frame row by row and re-emits it as per-slice column chunks
// in the order consumed by the multi-core multiplier
`timescale 1ns/10ps

module blk_conv_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  mat_data_pkg::row_t          in_row,
    output logic                        out_valid,
    input  logic                        out_ready,
    output mat_data_pkg::chunk_t        out_chunk,
    output conv_ctrl_pkg::chunk_flags_t out_flags
);

    logic                    wr_en;
    mat_data_pkg::row_addr_t wr_addr;
    mat_data_pkg::row_t      wr_row;
    mat_data_pkg::row_addr_t rd_addr;
    mat_data_pkg::row_t      rd_row;
    logic                    frame_full;
    logic                    frame_done;

    row_ingest u_ingest (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_row     (in_row),
        .frame_done (frame_done),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_row     (wr_row),
        .frame_full (frame_full)
    );

    row_buffer_ram u_buffer (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_row  (wr_row),
        .rd_addr (rd_addr),
        .rd_row  (rd_row)
    );

    slice_emitter u_emitter (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_full (frame_full),
        .frame_done (frame_done),
        .rd_addr    (rd_addr),
        .rd_row     (rd_row),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_chunk  (out_chunk),
        .out_flags  (out_flags)
    );

endmodule

// ==== verilog/slice_emitter.sv ====
// Slice emitter
// Loads one slice of rows from the frame store at a time and streams it out
// as column chunks, one per transfer, with slice and frame end flags
`timescale 1ns/10ps
`include "blk_conv_defs.svh"

module slice_emitter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        frame_full,
    output logic                        frame_done,
    output mat_data_pkg::row_addr_t     rd_addr,
    input  mat_data_pkg::row_t          rd_row,
    output logic                        out_valid,
    input  logic                        out_ready,
    output mat_data_pkg::chunk_t        out_chunk,
    output conv_ctrl_pkg::chunk_flags_t out_flags
);

    localparam int LD_W        = $clog2(`BC_SLICE_ROWS + 1);
    localparam int CAP_W       = (`BC_SLICE_ROWS > 1) ? $clog2(`BC_SLICE_ROWS) : 1;
    localparam int CHUNK_W     = (`BC_CHUNKS_PER_ROW > 1) ? $clog2(`BC_CHUNKS_PER_ROW) : 1;
    localparam int SLICE_W     = (`BC_SLICES > 1) ? $clog2(`BC_SLICES) : 1;
    // One extra cycle covers the store's read latency
    localparam int LOAD_CYCLES = `BC_SLICE_ROWS + 1;

    conv_ctrl_pkg::emit_state_t state;

    logic [LD_W-1:0]    ld_idx;
    logic [CAP_W-1:0]   cap_idx;
    logic               cap_en;
    logic [CHUNK_W-1:0] chunk_idx;
    logic [SLICE_W-1:0] slice_idx;
    logic               chunk_last;
    logic               slice_final;
    logic               xfer;

    mat_data_pkg::row_t slice_rows [`BC_SLICE_ROWS];

    assign chunk_last  = (chunk_idx == CHUNK_W'(`BC_CHUNKS_PER_ROW - 1));
    assign slice_final = (slice_idx == SLICE_W'(`BC_SLICES - 1));
    assign out_valid   = (state == conv_ctrl_pkg::EMIT);
    assign xfer        = out_valid && out_ready;
    assign frame_done  = xfer && chunk_last && slice_final;

    assign out_flags.slice_last = chunk_last;
    assign out_flags.frame_last = chunk_last && slice_final;

    // Frame row of the slice row being fetched
    assign rd_addr = mat_data_pkg::row_addr_t'(slice_idx * `BC_SLICE_ROWS + ld_idx);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= conv_ctrl_pkg::IDLE;
            ld_idx    <= '0;
            cap_en    <= 1'b0;
            chunk_idx <= '0;
            slice_idx <= '0;
        end else begin
            cap_en <= (state == conv_ctrl_pkg::LOAD) && (ld_idx < LD_W'(`BC_SLICE_ROWS));
            case (state)
                conv_ctrl_pkg::IDLE: begin
                    if (frame_full) begin
                        state     <= conv_ctrl_pkg::LOAD;
                        ld_idx    <= '0;
                        chunk_idx <= '0;
                        slice_idx <= '0;
                    end
                end
                conv_ctrl_pkg::LOAD: begin
                    // Last cycle only waits for the final read to land
                    if (ld_idx == LD_W'(`BC_SLICE_ROWS)) begin
                        state <= conv_ctrl_pkg::EMIT;
                    end else begin
                        ld_idx <= ld_idx + 1'b1;
                    end
                end
                conv_ctrl_pkg::EMIT: begin
                    if (xfer) begin
                        if (chunk_last) begin
                            chunk_idx <= '0;
                            ld_idx    <= '0;
                            if (slice_final) begin
                                state     <= conv_ctrl_pkg::IDLE;
                                slice_idx <= '0;
                            end else begin
                                state     <= conv_ctrl_pkg::LOAD;
                                slice_idx <= slice_idx + 1'b1;
                            end
                        end else begin
                            chunk_idx <= chunk_idx + 1'b1;
                        end
                    end
                end
                default: state <= conv_ctrl_pkg::IDLE;
            endcase
        end
    end

    // Capture trails the read index by one cycle
    always_ff @(posedge clk) begin
        cap_idx <= CAP_W'(ld_idx);
        if (cap_en) begin
            slice_rows[cap_idx] <= rd_row;
        end
    end

    // Same column pair from every slice row
    always_comb begin
        for (int r = 0; r < `BC_SLICE_ROWS; r++) begin
            out_chunk[r] = slice_rows[r][chunk_idx * `BC_BLOCK_SIZE +: `BC_BLOCK_SIZE];
        end
    end

    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_chunk) && $stable(out_flags)
    );

    // A slice load keeps the output quiet for its full length, then presents data
    a_load_quiet: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == conv_ctrl_pkg::LOAD && ld_idx == '0) |->
            (!out_valid) [*LOAD_CYCLES] ##1 out_valid
    );

endmodule

// ==== verilog/row_buffer_ram.sv ====
// Frame store
// Holds every row of one frame, since a chunk gathers rows that
// arrived far apart. One write port, one read port with registered output
`timescale 1ns/10ps
`include "blk_conv_defs.svh"

module row_buffer_ram (
    input  logic                    clk,
    input  logic                    wr_en,
    input  mat_data_pkg::row_addr_t wr_addr,
    input  mat_data_pkg::row_t      wr_row,
    input  mat_data_pkg::row_addr_t rd_addr,
    output mat_data_pkg::row_t      rd_row
);

    mat_data_pkg::row_t mem [`BC_ROW];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_row;
        end
    end

    // Data appears the cycle after the address
    always_ff @(posedge clk) begin
        rd_row <= mem[rd_addr];
    end

endmodule

// ==== verilog/row_ingest.sv ====
// Row ingest
// Accepts frame rows from the input stream and writes them to the frame store,
// then closes the input until the emitter reports the frame as sent
`timescale 1ns/10ps
`include "blk_conv_defs.svh"

module row_ingest (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  mat_data_pkg::row_t      in_row,
    input  logic                    frame_done,
    output logic                    wr_en,
    output mat_data_pkg::row_addr_t wr_addr,
    output mat_data_pkg::row_t      wr_row,
    output logic                    frame_full
);

    localparam mat_data_pkg::row_addr_t LAST_ROW = mat_data_pkg::row_addr_t'(`BC_ROW - 1);

    mat_data_pkg::row_addr_t row_cnt;
    logic                    accept;

    assign accept = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_ready   <= 1'b1;
            row_cnt    <= '0;
            wr_en      <= 1'b0;
            frame_full <= 1'b0;
        end else begin
            wr_en      <= accept;
            // Frame is complete once the last row has been written
            frame_full <= wr_en && (wr_addr == LAST_ROW);
            if (accept) begin
                if (row_cnt == LAST_ROW) begin
                    in_ready <= 1'b0;
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end else if (frame_done) begin
                // Emitter is finished, open up for the next frame
                row_cnt  <= '0;
                in_ready <= 1'b1;
            end
        end
    end

    // Write port registers
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_addr <= row_cnt;
            wr_row  <= in_row;
        end
    end

    // With the input closed only the last row of the frame may still be written
    a_no_write_when_closed: assert property (
        @(posedge clk) disable iff (!rst_n)
        !in_ready |-> !wr_en || ($fell(in_ready) && wr_addr == LAST_ROW)
    );

endmodule

// ==== verilog/conv_ctrl_pkg.sv ====
// Converter control types
// Emitter FSM states and the status flags that ride along with each chunk

package conv_ctrl_pkg;

    // Emitter FSM
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        EMIT
    } emit_state_t;

    // Travels with every output chunk
    typedef struct packed {
        logic slice_last;   // last chunk of the current slice
        logic frame_last;   // last chunk of the whole frame
    } chunk_flags_t;

endpackage

// ==== verilog/mat_data_pkg.sv ====
// Matrix data types
// Elements, full frame rows and the chunk that feeds all cores at once
`include "blk_conv_defs.svh"

package mat_data_pkg;

    // One matrix element
    typedef logic [`BC_WIDTH-1:0] elem_t;

    // Full row, element 0 in the most significant position
    typedef elem_t [0:`BC_COL-1] row_t;

    // Adjacent columns taken from one slice row,
    // lower column index more significant
    typedef elem_t [0:`BC_BLOCK_SIZE-1] group_t;

    // Output chunk, slice row 0 in the most significant group
    typedef group_t [0:`BC_SLICE_ROWS-1] chunk_t;

    // Row index inside the frame store
    typedef logic [$clog2(`BC_ROW)-1:0] row_addr_t;

endpackage

// ==== verilog/blk_conv_defs.svh ====
// Matrix shape and element width for the row-to-block converter
// Derived values describe how a frame splits into slices and chunks
`ifndef BLK_CONV_DEFS_SVH
`define BLK_CONV_DEFS_SVH

// Element and frame geometry
`define BC_WIDTH          16
`define BC_COL            8
`define BC_ROW            8

// Multiplier array shape
`define BC_BLOCK_SIZE     2
`define BC_NUM_CORES      2

// ROW must divide by SLICE_ROWS and COL by BLOCK_SIZE
`define BC_SLICE_ROWS     (`BC_BLOCK_SIZE * `BC_NUM_CORES)
`define BC_CHUNKS_PER_ROW (`BC_COL / `BC_BLOCK_SIZE)
`define BC_SLICES         (`BC_ROW / `BC_SLICE_ROWS)

`endif
